// ==== hw/bus_cfg_pkg.sv ====
`default_nettype none

package bus_cfg_pkg;

    // bus population
    localparam int NUM_MASTERS = 2;
    localparam int NUM_SLAVES  = 3;    // slave id 0 means no slave

    // word count of each slave, indexed by slave id minus one
    localparam int SLAVE_DEPTHS [NUM_SLAVES] = '{4096, 4096, 2048};

    localparam int DATA_WIDTH     = 16;
    localparam int ADDR_WIDTH     = 12;   // covers the deepest slave
    localparam int SLAVE_ID_WIDTH = 2;

    // externally entered write words per master
    localparam int BANK_DEPTH = 16;

    // cycles that each configuration beat is held on the command port
    localparam int BEAT_CYCLES = 2;

    typedef logic [DATA_WIDTH-1:0]     data_word_t;
    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [SLAVE_ID_WIDTH-1:0] slave_id_t;

    // bank index and word count, count reaches BANK_DEPTH itself
    typedef logic [$clog2(BANK_DEPTH)-1:0] bank_ptr_t;
    typedef logic [$clog2(BANK_DEPTH):0]   bank_count_t;

endpackage : bus_cfg_pkg

`default_nettype wire

// ==== hw/setup_pkg.sv ====
`default_nettype none

package setup_pkg;

    // operator menu phases, in walking order
    typedef enum logic [3:0] {
        slave_sel,
        rdwr_sel,
        ext_sel,
        entry_m0,
        entry_m1,
        first_addr_m0,
        first_addr_m1,
        length_m0,
        length_m1,
        configuring,
        ready,
        communicating,
        done
    } phase_t;

    // master configuration sequencer
    typedef enum logic [2:0] {
        idle,
        beat_first,
        beat_middle,
        beat_last,
        launch
    } cfg_state_t;

    // settings captured by the menu for one master
    typedef struct packed {
        bus_cfg_pkg::slave_id_t slave_id;
        logic                   rd_wr;       // 1 is write
        logic                   ext_write;   // write words from the bank
        bus_cfg_pkg::addr_t     first_addr;
        bus_cfg_pkg::addr_t     last_addr;
    } master_setup_t;

    // command port of one bus master
    typedef struct packed {
        logic                    start;
        logic                    eoc;        // end of communication
        logic                    rd_wr;
        logic                    ext_write;
        logic                    burst;
        bus_cfg_pkg::slave_id_t  slave_id;
        bus_cfg_pkg::addr_t      address;
        bus_cfg_pkg::data_word_t data;
    } master_cmd_t;

    // one word committed into the write data bank
    typedef struct packed {
        logic                    valid;
        logic                    master;
        bus_cfg_pkg::data_word_t data;
    } bank_write_t;

endpackage : setup_pkg

`default_nettype wire

// ==== hw/setup_menu.sv ====
`timescale 1ns/1ps
`default_nettype none

module setup_menu (
    input  wire logic                    clk,
    input  wire logic                    rstN,
    input  wire bus_cfg_pkg::data_word_t sw,
    input  wire logic                    step,
    input  wire logic                    next_word,
    input  wire logic [1:0]              master_done,
    input  wire logic                    config_done,
    output setup_pkg::phase_t            phase,
    output setup_pkg::master_setup_t     setup [bus_cfg_pkg::NUM_MASTERS],
    output setup_pkg::bank_write_t       bank_wr,
    output logic                         config_go,
    output logic                         launch_go,
    output logic                         skip_go
);
    import bus_cfg_pkg::*;
    import setup_pkg::*;

    phase_t phase_next;
    logic   in_entry;
    logic   run_done;

    // highest legal address of the chosen slave or of the first slave for id 0
    function automatic addr_t slave_top(slave_id_t id);
        int idx;
        idx = (id == '0) ? 0 : int'(id) - 1;
        return addr_t'(SLAVE_DEPTHS[idx] - 1);
    endfunction

    // first address plus length held inside the slave
    function automatic addr_t clamp_last(addr_t first, data_word_t len, slave_id_t id);
        logic [DATA_WIDTH:0] sum;
        addr_t               top_addr;
        top_addr = slave_top(id);
        sum      = {1'b0, len} + first;
        if (sum > top_addr)
            return top_addr;
        return addr_t'(sum);
    endfunction

    assign in_entry = (phase == entry_m0) || (phase == entry_m1);

    // a step in an entry phase also commits the word on the switches
    assign bank_wr.valid  = in_entry && (next_word || step);
    assign bank_wr.master = (phase == entry_m1);
    assign bank_wr.data   = sw;

    assign config_go = step && (phase == length_m1);
    assign launch_go = step && (phase == ready);
    assign skip_go   = step && (phase == slave_sel) && (sw[3:0] == '0);

    // an unused master counts as finished
    assign run_done = (master_done == 2'b11) ||
                      ((setup[0].slave_id == '0) && master_done[1]) ||
                      ((setup[1].slave_id == '0) && master_done[0]);

    always_comb begin
        phase_next = phase;
        case (phase)
            slave_sel:     if (step) phase_next = (sw[3:0] == '0) ? done : rdwr_sel;
            rdwr_sel:      if (step) phase_next = ext_sel;
            ext_sel: begin
                if (step) begin
                    if (sw[0])
                        phase_next = entry_m0;
                    else if (sw[1])
                        phase_next = entry_m1;
                    else
                        phase_next = first_addr_m0;
                end
            end
            entry_m0:      if (step) phase_next = setup[1].ext_write ? entry_m1 : first_addr_m0;
            entry_m1:      if (step) phase_next = first_addr_m0;
            first_addr_m0: if (step) phase_next = first_addr_m1;
            first_addr_m1: if (step) phase_next = length_m0;
            length_m0:     if (step) phase_next = length_m1;
            length_m1:     if (step) phase_next = configuring;
            configuring:   if (config_done) phase_next = ready;
            ready:         if (step) phase_next = communicating;
            communicating: if (run_done) phase_next = done;
            default:       phase_next = phase;   // done holds until reset
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= slave_sel;
            setup <= '{default: '0};
        end else begin
            phase <= phase_next;
            // fields follow the switches while their phase is active
            case (phase)
                slave_sel: begin
                    for (int i = 0; i < NUM_MASTERS; i++)
                        setup[i].slave_id <= sw[SLAVE_ID_WIDTH*i +: SLAVE_ID_WIDTH];
                end
                rdwr_sel: begin
                    for (int i = 0; i < NUM_MASTERS; i++)
                        setup[i].rd_wr <= sw[i];
                end
                ext_sel: begin
                    for (int i = 0; i < NUM_MASTERS; i++)
                        setup[i].ext_write <= sw[i];
                end
                first_addr_m0: setup[0].first_addr <= addr_t'(sw);
                first_addr_m1: setup[1].first_addr <= addr_t'(sw);
                length_m0: setup[0].last_addr <= clamp_last(setup[0].first_addr, sw,
                                                            setup[0].slave_id);
                length_m1: setup[1].last_addr <= clamp_last(setup[1].first_addr, sw,
                                                            setup[1].slave_id);
                default: ;
            endcase
        end
    end

    // the sequencer reports completion only while configuring
    a_config_done_phase: assert property (@(posedge clk) disable iff (!rstN)
        config_done |-> (phase == configuring));

endmodule : setup_menu

`default_nettype wire

// ==== hw/write_data_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_data_bank (
    input  wire logic                    clk,
    input  wire logic                    rstN,
    input  wire setup_pkg::bank_write_t  wr,
    input  wire logic                    rd_master,
    input  wire bus_cfg_pkg::bank_ptr_t  rd_ptr,
    output bus_cfg_pkg::data_word_t      rd_data,
    output bus_cfg_pkg::bank_count_t     count [bus_cfg_pkg::NUM_MASTERS]
);
    import bus_cfg_pkg::*;

    data_word_t mem [NUM_MASTERS][BANK_DEPTH];
    bank_ptr_t  wr_ptr;
    logic       wr_ok;

    // the count of a master doubles as its write pointer
    assign wr_ptr = bank_ptr_t'(count[wr.master]);
    assign wr_ok  = wr.valid && (count[wr.master] < BANK_DEPTH);   // extra words dropped

    always_ff @(posedge clk) begin
        if (wr_ok)
            mem[wr.master][wr_ptr] <= wr.data;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '{default: '0};
        end else if (wr_ok) begin
            count[wr.master] <= count[wr.master] + 1'b1;
        end
    end

    assign rd_data = mem[rd_master][rd_ptr];   // asynchronous read

    for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_count_chk
        a_count_bound: assert property (@(posedge clk) disable iff (!rstN)
            count[i] <= BANK_DEPTH);
    end

endmodule : write_data_bank

`default_nettype wire

// ==== hw/master_config_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module master_config_sequencer (
    input  wire logic                     clk,
    input  wire logic                     rstN,
    input  wire setup_pkg::master_setup_t setup [bus_cfg_pkg::NUM_MASTERS],
    input  wire bus_cfg_pkg::bank_count_t count [bus_cfg_pkg::NUM_MASTERS],
    input  wire bus_cfg_pkg::data_word_t  rd_data,
    input  wire logic                     config_go,
    input  wire logic                     launch_go,
    input  wire logic                     skip_go,
    output logic                          rd_master,
    output bus_cfg_pkg::bank_ptr_t        rd_ptr,
    output setup_pkg::master_cmd_t        cmd [bus_cfg_pkg::NUM_MASTERS],
    output logic                          config_done
);
    import bus_cfg_pkg::*;
    import setup_pkg::*;

    cfg_state_t state, state_next;
    logic       mst, mst_next;          // master being configured
    bank_ptr_t  ptr, ptr_next;          // bank word of the current beat
    logic [$clog2(BEAT_CYCLES)-1:0] beat_cnt;

    logic        beat_end;
    logic        load;                  // a new beat goes out on the next edge
    bank_count_t cur_cnt;
    bank_count_t nxt_cnt;
    bank_ptr_t   last_ptr;
    logic        has_middle;

    assign beat_end   = (beat_cnt == BEAT_CYCLES - 1);
    assign cur_cnt    = count[mst];
    assign nxt_cnt    = count[mst_next];
    assign last_ptr   = (cur_cnt >= 2) ? bank_ptr_t'(cur_cnt - 1'b1) : '0;
    assign has_middle = setup[mst].ext_write && (cur_cnt > 2);

    always_comb begin
        state_next = state;
        mst_next   = mst;
        ptr_next   = ptr;
        load       = 1'b0;
        case (state)
            idle: begin
                if (config_go) begin
                    state_next = beat_first;
                    mst_next   = 1'b0;
                    ptr_next   = '0;
                    load       = 1'b1;
                end else if (launch_go) begin
                    state_next = launch;
                end
            end
            beat_first: begin
                if (beat_end) begin
                    load       = 1'b1;
                    state_next = has_middle ? beat_middle : beat_last;
                    ptr_next   = has_middle ? bank_ptr_t'(1) : last_ptr;
                end
            end
            beat_middle: begin
                if (beat_end) begin
                    load = 1'b1;
                    if (bank_count_t'(ptr) == cur_cnt - 2'd2) begin
                        state_next = beat_last;
                        ptr_next   = last_ptr;
                    end else begin
                        ptr_next = ptr + 1'b1;
                    end
                end
            end
            beat_last: begin
                if (beat_end) begin
                    if (mst == NUM_MASTERS - 1) begin
                        state_next = idle;
                    end else begin
                        state_next = beat_first;
                        mst_next   = mst + 1'b1;
                        ptr_next   = '0;
                        load       = 1'b1;
                    end
                end
            end
            default: state_next = idle;     // launch lasts one cycle
        endcase
    end

    // bank is read at the word of the beat about to go out
    assign rd_master = mst_next;
    assign rd_ptr    = ptr_next;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= idle;
            mst         <= 1'b0;
            ptr         <= '0;
            beat_cnt    <= '0;
            config_done <= 1'b0;
            cmd         <= '{default: '0};
        end else begin
            state       <= state_next;
            mst         <= mst_next;
            ptr         <= ptr_next;
            beat_cnt    <= load ? '0 : beat_cnt + 1'b1;
            config_done <= (state == beat_last) && beat_end && (mst == NUM_MASTERS - 1);
            for (int i = 0; i < NUM_MASTERS; i++) begin
                cmd[i].start <= launch_go;   // both masters together
                cmd[i].eoc   <= skip_go;
            end
            if (load) begin
                cmd[mst_next].start     <= (state_next != beat_middle);
                cmd[mst_next].rd_wr     <= setup[mst_next].rd_wr;
                cmd[mst_next].ext_write <= setup[mst_next].ext_write;
                cmd[mst_next].slave_id  <= setup[mst_next].slave_id;
                cmd[mst_next].burst     <= (nxt_cnt >= 2);
                cmd[mst_next].address   <= (state_next == beat_first) ?
                                           setup[mst_next].first_addr :
                                           setup[mst_next].last_addr;
                cmd[mst_next].data      <= (nxt_cnt == '0) ? '0 : rd_data;
            end
        end
    end

    a_start_both: assert property (@(posedge clk) disable iff (!rstN)
        (cmd[0].start && cmd[1].start) |-> (state == launch));

endmodule : master_config_sequencer

`default_nettype wire

// ==== hw/setup_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module setup_controller (
    input  wire logic                    clk,
    input  wire logic                    rstN,
    input  wire bus_cfg_pkg::data_word_t sw,
    input  wire logic                    step,          // one-cycle strobe
    input  wire logic                    next_word,     // one-cycle strobe
    input  wire logic [1:0]              master_done,
    output setup_pkg::master_cmd_t       cmd [bus_cfg_pkg::NUM_MASTERS],
    output setup_pkg::phase_t            phase
);
    import bus_cfg_pkg::*;
    import setup_pkg::*;

    master_setup_t setup [NUM_MASTERS];
    bank_write_t   bank_wr;
    bank_count_t   count [NUM_MASTERS];
    logic          rd_master;
    bank_ptr_t     rd_ptr;
    data_word_t    rd_data;
    logic          config_go;
    logic          launch_go;
    logic          skip_go;
    logic          config_done;

    // operator menu, produces settings and bank words
    setup_menu setup_menu_inst (
        .clk,
        .rstN,
        .sw,
        .step,
        .next_word,
        .master_done,
        .config_done,
        .phase,
        .setup,
        .bank_wr,
        .config_go,
        .launch_go,
        .skip_go
    );

    write_data_bank write_data_bank_inst (
        .clk,
        .rstN,
        .wr        (bank_wr),
        .rd_master,
        .rd_ptr,
        .rd_data,
        .count
    );

    // drives the master command ports
    master_config_sequencer master_config_sequencer_inst (
        .clk,
        .rstN,
        .setup,
        .count,
        .rd_data,
        .config_go,
        .launch_go,
        .skip_go,
        .rd_master,
        .rd_ptr,
        .cmd,
        .config_done
    );

endmodule : setup_controller

`default_nettype wire

// ==== bench/setup_controller_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module setup_controller_tb;
    import bus_cfg_pkg::*;
    import setup_pkg::*;

    localparam int DRIVE_DLY   = 2;      // ns after the rising edge
    localparam int RESET_CYCLES = 3;
    localparam int MENU_CYCLES = 24;     // menu steps and entered words of one run
    localparam int CFG_WAIT    = BEAT_CYCLES * NUM_MASTERS * BANK_DEPTH + 4;
    localparam int COMM_CYCLES = 16;
    localparam int NUM_RUNS    = 6;
    localparam int CYCLE_LIMIT = NUM_RUNS * (RESET_CYCLES + MENU_CYCLES + CFG_WAIT + COMM_CYCLES)
                                 + 100;

    logic        clk;
    logic        rstN;
    data_word_t  sw;
    logic        step;
    logic        next_word;
    logic [1:0]  master_done;
    master_cmd_t cmd [NUM_MASTERS];
    phase_t      phase;

    // settings of the current run, as the operator enters them
    slave_id_t  m_slave [NUM_MASTERS];
    logic [NUM_MASTERS-1:0] m_rdwr;
    logic [NUM_MASTERS-1:0] m_ext;
    addr_t      m_first [NUM_MASTERS];
    data_word_t m_len [NUM_MASTERS];
    data_word_t m_words [NUM_MASTERS][BANK_DEPTH];
    int         m_cnt [NUM_MASTERS];

    int cfg_cyc;
    int cfg_total;
    bit cfg_active;
    int errors;
    int checks;
    int tests;
    int err_mark;
    int cycle_cnt;

    setup_controller setup_controller_inst (
        .clk,
        .rstN,
        .sw,
        .step,
        .next_word,
        .master_done,
        .cmd,
        .phase
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic int slave_depth(slave_id_t id);
        return (id == '0) ? SLAVE_DEPTHS[0] : SLAVE_DEPTHS[int'(id) - 1];   // no slave, like slave 1
    endfunction

    // last address is first plus length, held to the slave's top word
    function automatic addr_t expected_last(int m);
        int top;
        int sum;
        top = slave_depth(m_slave[m]) - 1;
        sum = int'(m_first[m]) + int'(m_len[m]);
        return addr_t'((sum > top) ? top : sum);
    endfunction

    function automatic int beat_count(int m);
        return 2 + ((m_ext[m] && m_cnt[m] > 2) ? m_cnt[m] - 2 : 0);
    endfunction

    function automatic data_word_t beat_word(int m, int beat, int nb);
        if (m_cnt[m] == 0)
            return '0;
        if (beat < nb - 1)
            return m_words[m][beat];
        return m_words[m][m_cnt[m] - 1];   // one word only gives word 0
    endfunction

    // reference model: command of master m in cycle cyc of configuring
    function automatic master_cmd_t expected_cmd(int m, int cyc);
        master_cmd_t c;
        int          rel;
        int          nb;
        int          beat;
        c   = '0;
        rel = (m == 0) ? cyc : cyc - BEAT_CYCLES * beat_count(0);
        if (rel < 0)
            return c;                      // master 1 waits its turn
        nb   = beat_count(m);
        beat = (rel < BEAT_CYCLES * nb) ? rel / BEAT_CYCLES : nb - 1;
        c.start     = (rel < BEAT_CYCLES * nb) && (rel % BEAT_CYCLES == 0) &&
                      (beat == 0 || beat == nb - 1);
        c.rd_wr     = m_rdwr[m];
        c.ext_write = m_ext[m];
        c.burst     = (m_cnt[m] >= 2);
        c.slave_id  = m_slave[m];
        c.address   = (beat == 0) ? m_first[m] : expected_last(m);  // middle beats keep last
        c.data      = beat_word(m, beat, nb);
        return c;
    endfunction

    task automatic check_cmd(string what, master_cmd_t act, master_cmd_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s cmd %h, expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_phase(string what, phase_t act, phase_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s phase %s, expected %s", $time, what, act.name(),
                     exp.name());
        end
    endtask

    task automatic check_addr(string what, addr_t act, addr_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s address %h, expected %h", $time, what, act, exp);
        end
    endtask

    // compares both command ports on every falling edge of configuring
    always @(negedge clk) begin
        if (cfg_active) begin
            if (cfg_cyc <= cfg_total) begin
                check_phase("configuring", phase, configuring);
                for (int m = 0; m < NUM_MASTERS; m++)
                    check_cmd($sformatf("config m%0d cycle %0d", m, cfg_cyc), cmd[m],
                              expected_cmd(m, cfg_cyc));
            end else begin
                check_phase("config done", phase, ready);
                cfg_active = 1'b0;
            end
            cfg_cyc++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, a test did not finish", cycle_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic tick();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic do_reset();
        rstN        = 1'b0;
        step        = 1'b0;
        next_word   = 1'b0;
        master_done = '0;
        sw          = '0;
        cfg_active  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rstN = 1'b1;
    endtask

    task automatic press_step(data_word_t value);
        sw   = value;
        step = 1'b1;
        tick();
        step = 1'b0;
    endtask

    task automatic enter_word(data_word_t value);
        sw        = value;
        next_word = 1'b1;
        tick();
        next_word = 1'b0;
    endtask

    task automatic set_master(int m, slave_id_t sid, logic wr, logic ext, int nwords,
                              int first_base, int first_span, int len_base, int len_span);
        m_slave[m] = sid;
        m_rdwr[m]  = wr;
        m_ext[m]   = ext;
        m_cnt[m]   = nwords;
        for (int i = 0; i < nwords; i++)
            m_words[m][i] = data_word_t'($urandom);
        m_first[m] = addr_t'(first_base + int'($urandom % first_span));
        m_len[m]   = data_word_t'(len_base + int'($urandom % len_span));
    endtask

    // walks the menu up to ready, the compare process follows configuring
    task automatic run_menu();
        int n;
        press_step(data_word_t'({m_slave[1], m_slave[0]}));
        press_step(data_word_t'(m_rdwr));
        press_step(data_word_t'(m_ext));
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if (m_ext[m]) begin
                for (int i = 0; i < m_cnt[m] - 1; i++)
                    enter_word(m_words[m][i]);
                press_step(m_words[m][m_cnt[m] - 1]);    // step commits the last word
            end
        end
        press_step(data_word_t'(m_first[0]));
        press_step(data_word_t'(m_first[1]));
        press_step(m_len[0]);
        press_step(m_len[1]);
        cfg_cyc    = 0;
        cfg_total  = BEAT_CYCLES * (beat_count(0) + beat_count(1));
        cfg_active = 1'b1;
        for (n = 0; n < CFG_WAIT && cfg_active; n++)
            tick();
        if (cfg_active) begin
            errors++;
            $display("configuration never reached ready within %0d cycles", CFG_WAIT);
            cfg_active = 1'b0;
        end
    endtask

    task automatic launch_masters();
        master_cmd_t exp;
        press_step('0);
        @(negedge clk);
        check_phase("launch", phase, communicating);
        for (int m = 0; m < NUM_MASTERS; m++) begin
            exp       = expected_cmd(m, cfg_total);
            exp.start = 1'b1;
            check_cmd($sformatf("launch m%0d", m), cmd[m], exp);
        end
        @(negedge clk);
        for (int m = 0; m < NUM_MASTERS; m++)
            check_cmd($sformatf("after launch m%0d", m), cmd[m], expected_cmd(m, cfg_total));
        tick();
    endtask

    task automatic report_test(string name);
        tests++;
        if (errors == err_mark)
            $display("test %0d %s: ok", tests, name);
        else
            $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        master_cmd_t exp;
        void'($urandom(32'he25986a6));
        errors     = 0;
        checks     = 0;
        tests      = 0;
        err_mark   = 0;
        cycle_cnt  = 0;
        cfg_cyc    = 0;
        cfg_total  = 0;
        do_reset();

        @(negedge clk);
        check_phase("reset", phase, slave_sel);
        for (int m = 0; m < NUM_MASTERS; m++)
            check_cmd("reset", cmd[m], '0);
        report_test("reset state");

        // slave 3 is only 2048 words deep, so master 0 clamps
        set_master(0, 2'd3, 1'b0, 1'b0, 0, 1024, 512, 2048, 1024);
        set_master(1, 2'd1, 1'b0, 1'b0, 0, 0, 1024, 0, 1024);
        tick();
        run_menu();
        check_addr("clamped m0", cmd[0].address, addr_t'(SLAVE_DEPTHS[2] - 1));
        check_addr("last m1", cmd[1].address, expected_last(1));
        report_test("both masters read");

        do_reset();
        set_master(0, 2'd1, 1'b1, 1'b1, 5, 0, 1024, 0, 256);
        set_master(1, 2'd2, 1'b1, 1'b1, 2, 0, 1024, 0, 256);
        run_menu();
        do_reset();
        set_master(0, 2'd2, 1'b1, 1'b1, 1, 0, 1024, 0, 256);
        set_master(1, 2'd3, 1'b1, 1'b0, 0, 0, 1024, 0, 256);
        run_menu();
        report_test("external write words");

        launch_masters();
        report_test("launch");

        // both masters used, one flag alone is not enough
        master_done = 2'b01;
        repeat (2) begin
            @(negedge clk);
            check_phase("m0 done only", phase, communicating);
        end
        tick();
        master_done = 2'b10;
        repeat (2) begin
            @(negedge clk);
            check_phase("m1 done only", phase, communicating);
        end
        tick();
        master_done = 2'b11;
        tick();
        @(negedge clk);
        check_phase("both done", phase, done);
        tick();
        master_done = '0;

        do_reset();
        set_master(0, 2'd1, 1'b0, 1'b0, 0, 0, 1024, 0, 1024);
        set_master(1, 2'd0, 1'b0, 1'b0, 0, 0, 1024, 0, 1024);
        run_menu();
        launch_masters();
        master_done = 2'b01;
        tick();
        @(negedge clk);
        check_phase("m1 unused", phase, done);
        tick();
        report_test("done detection");

        do_reset();
        press_step(16'h5a30);     // upper switch bits do not matter
        @(negedge clk);
        check_phase("skip", phase, done);
        exp     = '0;
        exp.eoc = 1'b1;
        for (int m = 0; m < NUM_MASTERS; m++)
            check_cmd($sformatf("skip eoc m%0d", m), cmd[m], exp);
        @(negedge clk);
        for (int m = 0; m < NUM_MASTERS; m++)
            check_cmd($sformatf("after skip m%0d", m), cmd[m], '0);
        check_phase("after skip", phase, done);
        report_test("no slave chosen");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule : setup_controller_tb

`default_nettype wire

// ==== sources.f ====
hw/bus_cfg_pkg.sv
hw/setup_pkg.sv
hw/setup_menu.sv
hw/write_data_bank.sv
hw/master_config_sequencer.sv
hw/setup_controller.sv
bench/setup_controller_tb.sv

// ==== Bender.yml ====
package:
  name: setup_controller

sources:
  - target: any(rtl, test)
    files:
      - hw/bus_cfg_pkg.sv
      - hw/setup_pkg.sv
      - hw/setup_menu.sv
      - hw/write_data_bank.sv
      - hw/master_config_sequencer.sv
      - hw/setup_controller.sv
  - target: test
    files:
      - bench/setup_controller_tb.sv
